/* irq_vectors.txt */
# op a b (hex): W addr data, R addr expect, I irq pc, X addr window, N cycles,
# M mret, D cycles, S mcycle snapshot, C expected mcycle delta; one op per cycle
W 300 FFFFFFFF
R 300 00000088
W 300 00000000
W 304 FFFFFFFF
R 304 FFFF0888
W 305 00002003
R 305 00002001
W 341 12345677
R 341 12345674
R 123 00000000
I FFFFFFFF 00000000
R 344 FFFF0888
N 4
I 00000000 00000000
# direct mode, line 11
W 305 00001000
W 304 00000800
W 300 00000008
I 00000800 00004444
N 1
X 00001000 1
N 1
R 341 00004444
R 342 8000000B
R 300 00000080
# mret to mepc, pending line 11 traps again
I 00000800 00005550
M
X 00004444 1
X 00001000 1
N 3
R 341 00005550
# vectored mode, 20 beats 3 and 7, then 3 beats 7
W 305 00002001
W 304 FFFFFFFF
I 00100088 00006000
W 300 00000008
X 00002050 3
I 00000088 00006100
W 300 00000008
X 0000200C 3
# line 7 not enabled in mie
W 304 00000800
W 300 00000008
I 00000080 00007000
N 6
# mcycle write, then reads eleven cycles apart
W B00 00000100
R B00 00000100
D 5
R B00 00000106
S
D A
C 0000000B

/* flist.f */
irq_pkg.sv
irq_csr_regs.sv
irq_int_controller.sv
irq_trap_ctrl.sv
irq_core_top.sv
tb_irq_core.sv

/* tb_irq_core.sv */
//////////////////////////////////////////////////////////////////////
// Self-checking testbench for the interrupt path top level
// Replays the operations in irq_vectors.txt against the DUT
//////////////////////////////////////////////////////////////////////

module tb_irq_core;

  logic                          clk_i;
  logic                          rst_i;
  logic [irq_pkg::XLEN-1:0]      irq_i;
  logic                          csr_we_i;
  logic [irq_pkg::CSR_ADDR_W-1:0] csr_addr_i;
  logic [irq_pkg::XLEN-1:0]      csr_wdata_i;
  logic [irq_pkg::CSR_ADDR_W-1:0] csr_raddr_i;
  logic [irq_pkg::XLEN-1:0]      csr_rdata_o;
  logic [irq_pkg::XLEN-1:0]      pc_i;
  logic                          mret_i;
  logic                          redirect_o;
  logic [irq_pkg::XLEN-1:0]      redirect_addr_o;

  int    errors;
  int    checks;
  int    cycles;
  int    limit;
  // One entry per operation, code and two hex fields
  logic [7:0]  op_q[$];
  logic [31:0] a_q[$];
  logic [31:0] b_q[$];
  // mcycle low word from the last snapshot
  logic [irq_pkg::XLEN-1:0] snap;

  irq_core_top DUT (
    .clk_i           ( clk_i           ),
    .rst_i           ( rst_i           ),
    .irq_i           ( irq_i           ),
    .csr_we_i        ( csr_we_i        ),
    .csr_addr_i      ( csr_addr_i      ),
    .csr_wdata_i     ( csr_wdata_i     ),
    .csr_raddr_i     ( csr_raddr_i     ),
    .csr_rdata_o     ( csr_rdata_o     ),
    .pc_i            ( pc_i            ),
    .mret_i          ( mret_i          ),
    .redirect_o      ( redirect_o      ),
    .redirect_addr_o ( redirect_addr_o )
  );

  always #2 clk_i = ~clk_i;

  // Watchdog limit scales with the number of operations
  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= limit) begin
      $display("Run stopped, no progress after %0d cycles", cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // Step to the falling edge and drop the one-cycle strobes
  task automatic next_cycle();
    @(negedge clk_i);
    csr_we_i = 1'b0;
    mret_i   = 1'b0;
  endtask

  // Hex fields that follow each operation code
  function automatic int field_count(input logic [7:0] code);
    case (code)
      "W", "R", "I", "X": field_count = 2;
      "N", "D", "C":      field_count = 1;
      default:            field_count = 0;
    endcase
  endfunction

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("mismatch %s: got %08h expected %08h", name, got, exp);
      errors++;
    end
  endtask

  // Redirect must show up in one of the next window cycles
  task automatic expect_redirect(input logic [31:0] addr, input int window);
    bit seen;
    seen = 1'b0;
    for (int i = 0; i < window && !seen; i++) begin
      if (i > 0) begin
        next_cycle();
      end
      #1;
      if (redirect_o === 1'b1) begin
        seen = 1'b1;
        compare_word("redirect_addr_o", redirect_addr_o, addr);
      end
    end
    if (!seen) begin
      $display("Expected redirect to %08h did not come within %0d cycles", addr, window);
      errors++;
    end
  endtask

  // redirect_o held low for n cycles
  task automatic expect_quiet(input int n);
    for (int i = 0; i < n; i++) begin
      if (i > 0) begin
        next_cycle();
      end
      #1;
      checks++;
      if (redirect_o !== 1'b0) begin
        $display("Unexpected redirect to %08h during a quiet window", redirect_addr_o);
        errors++;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    int          fd;
    int          c;
    logic [7:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    int          n;

    clk_i       = 1'b0;
    rst_i       = 1'b1;
    irq_i       = '0;
    csr_we_i    = 1'b0;
    csr_addr_i  = '0;
    csr_wdata_i = '0;
    csr_raddr_i = '0;
    pc_i        = '0;
    mret_i      = 1'b0;
    errors      = 0;
    checks      = 0;
    cycles      = 0;
    limit       = 100;
    snap        = '0;

    fd = $fopen("irq_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file irq_vectors.txt");
      errors++;
    end else begin
      // Comment lines start with a hash and run to the end of the line
      while ($fscanf(fd, " %c", op) == 1) begin
        if (op == "#") begin
          c = $fgetc(fd);
          while (c != "\n" && c != -1) begin
            c = $fgetc(fd);
          end
        end else begin
          a = '0;
          b = '0;
          n = 0;
          if (field_count(op) == 2) begin
            n = $fscanf(fd, " %h %h", a, b);
          end else if (field_count(op) == 1) begin
            n = $fscanf(fd, " %h", a);
          end
          if (n != field_count(op)) begin
            $display("Vector operation %c has missing or bad fields", op);
            errors++;
          end
          op_q.push_back(op);
          a_q.push_back(a);
          b_q.push_back(b);
        end
      end
      $fclose(fd);
      limit = 20 * op_q.size() + 100;
    end

    repeat (4) @(negedge clk_i);
    rst_i = 1'b0;

    for (int i = 0; i < op_q.size(); i++) begin
      op = op_q[i];
      a  = a_q[i];
      b  = b_q[i];
      next_cycle();
      case (op)
        "W": begin
          csr_we_i    = 1'b1;
          csr_addr_i  = a[irq_pkg::CSR_ADDR_W-1:0];
          csr_wdata_i = b;
        end
        "R": begin
          csr_raddr_i = a[irq_pkg::CSR_ADDR_W-1:0];
          #1;
          compare_word("csr_rdata_o", csr_rdata_o, b);
        end
        "I": begin
          irq_i = a;
          pc_i  = b;
        end
        "M": mret_i = 1'b1;
        "X": expect_redirect(a, int'(b));
        "N": expect_quiet(int'(a));
        "D": begin
          for (int k = 1; k < int'(a); k++) begin
            next_cycle();
          end
        end
        "S": begin
          csr_raddr_i = irq_pkg::CSR_MCYCLE;
          #1;
          snap = csr_rdata_o;
        end
        "C": begin
          csr_raddr_i = irq_pkg::CSR_MCYCLE;
          #1;
          compare_word("csr_rdata_o delta", csr_rdata_o - snap, a);
        end
        default: begin
          $display("Unknown operation %c in vector entry %0d", op, i + 1);
          errors++;
        end
      endcase
    end

    next_cycle();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* irq_core_top.sv */
//////////////////////////////////////////////////////////////////////
// Top of the interrupt path: CSRs, interrupt and trap controllers.
// The environment plays the pipeline around it.
//////////////////////////////////////////////////////////////////////

module irq_core_top (
  input  logic                          clk_i,
  input  logic                          rst_i,

  // Interrupt lines
  input  logic [irq_pkg::XLEN-1:0]      irq_i,

  // CSR access
  input  logic                          csr_we_i,
  input  logic [irq_pkg::CSR_ADDR_W-1:0] csr_addr_i,
  input  logic [irq_pkg::XLEN-1:0]      csr_wdata_i,
  input  logic [irq_pkg::CSR_ADDR_W-1:0] csr_raddr_i,
  output logic [irq_pkg::XLEN-1:0]      csr_rdata_o,

  // Pipeline side
  input  logic [irq_pkg::XLEN-1:0]      pc_i,
  input  logic                          mret_i,
  output logic                          redirect_o,
  output logic [irq_pkg::XLEN-1:0]      redirect_addr_o
);

  // CSR block to the controllers
  logic [irq_pkg::XLEN-1:0]     mie;
  logic                         mstatus_mie;
  logic [irq_pkg::XLEN-1:0]     mtvec;
  logic [irq_pkg::XLEN-1:0]     mepc;

  // Interrupt controller outputs
  logic [irq_pkg::XLEN-1:0]     mip;
  logic                         irq_req;
  logic [irq_pkg::IRQ_ID_W-1:0] irq_id;

  // Trap controller strobes
  logic                         trap_take;
  logic                         mret_take;

  //////////////////////////////////////////////////////////////////////
  // CSRs
  //////////////////////////////////////////////////////////////////////

  irq_csr_regs csr_regs_i (
    .clk_i          ( clk_i         ),
    .rst_i          ( rst_i         ),
    .csr_we_i       ( csr_we_i      ),
    .csr_addr_i     ( csr_addr_i    ),
    .csr_wdata_i    ( csr_wdata_i   ),
    .csr_raddr_i    ( csr_raddr_i   ),
    .csr_rdata_o    ( csr_rdata_o   ),
    .mip_i          ( mip           ),
    .trap_take_i    ( trap_take     ),
    .trap_id_i      ( irq_id        ),
    .trap_pc_i      ( pc_i          ),
    .mret_take_i    ( mret_take     ),
    .mie_o          ( mie           ),
    .mstatus_mie_o  ( mstatus_mie   ),
    .mtvec_o        ( mtvec         ),
    .mepc_o         ( mepc          )
  );

  //////////////////////////////////////////////////////////////////////
  // Interrupt and trap control
  //////////////////////////////////////////////////////////////////////

  irq_int_controller int_controller_i (
    .clk_i          ( clk_i         ),
    .rst_i          ( rst_i         ),
    .irq_i          ( irq_i         ),
    .mie_i          ( mie           ),
    .mstatus_mie_i  ( mstatus_mie   ),
    .mip_o          ( mip           ),
    .irq_req_o      ( irq_req       ),
    .irq_id_o       ( irq_id        )
  );

  irq_trap_ctrl trap_ctrl_i (
    .clk_i           ( clk_i           ),
    .rst_i           ( rst_i           ),
    .irq_req_i       ( irq_req         ),
    .irq_id_i        ( irq_id          ),
    .mret_i          ( mret_i          ),
    .mtvec_i         ( mtvec           ),
    .mepc_i          ( mepc            ),
    .trap_take_o     ( trap_take       ),
    .mret_take_o     ( mret_take       ),
    .redirect_o      ( redirect_o      ),
    .redirect_addr_o ( redirect_addr_o )
  );

endmodule

/* irq_trap_ctrl.sv */
//////////////////////////////////////////////////////////////////////
// Trap controller: arbitrates mret against an interrupt request,
// strobes the CSR updates and issues a one-cycle redirect
//////////////////////////////////////////////////////////////////////

module irq_trap_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_i,

  // From interrupt controller
  input  logic                          irq_req_i,
  input  logic [irq_pkg::IRQ_ID_W-1:0]  irq_id_i,

  // Return strobe from the pipeline
  input  logic                          mret_i,

  // From CSR block
  input  logic [irq_pkg::XLEN-1:0]      mtvec_i,
  input  logic [irq_pkg::XLEN-1:0]      mepc_i,

  // To CSR block
  output logic                          trap_take_o,
  output logic                          mret_take_o,

  // To the pipeline
  output logic                          redirect_o,
  output logic [irq_pkg::XLEN-1:0]      redirect_addr_o
);

  logic                     redirect_q;
  logic [irq_pkg::XLEN-1:0] redirect_addr_q;
  logic [irq_pkg::XLEN-1:0] mtvec_base;
  logic [irq_pkg::XLEN-1:0] trap_addr;

  //////////////////////////////////////////////////////////////////////
  // Arbitration
  //////////////////////////////////////////////////////////////////////

  // mret beats a request in the same cycle
  assign mret_take_o = mret_i;
  assign trap_take_o = irq_req_i & ~mret_i;

  //////////////////////////////////////////////////////////////////////
  // Target address
  //////////////////////////////////////////////////////////////////////

  // Mode bits stripped from the base
  assign mtvec_base = {mtvec_i[irq_pkg::XLEN-1:2], 2'b00};

  // Vectored mode: one word per cause id
  always_comb begin
    if (mtvec_i[0]) begin
      trap_addr = mtvec_base + irq_pkg::XLEN'({irq_id_i, 2'b00});
    end else begin
      trap_addr = mtvec_base;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Redirect register
  //////////////////////////////////////////////////////////////////////

  // High for exactly one cycle per take
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      redirect_q <= 1'b0;
    end else begin
      redirect_q <= trap_take_o | mret_take_o;
    end
  end

  // mepc captured before the CSR block sees this edge
  always_ff @(posedge clk_i) begin
    if (mret_take_o) begin
      redirect_addr_q <= mepc_i;
    end else if (trap_take_o) begin
      redirect_addr_q <= trap_addr;
    end
  end

  assign redirect_o      = redirect_q;
  assign redirect_addr_o = redirect_addr_q;

endmodule

/* irq_int_controller.sv */
//////////////////////////////////////////////////////////////////////
// Interrupt controller: samples the irq lines into mip and picks the
// winning enabled line for the trap controller
//////////////////////////////////////////////////////////////////////

module irq_int_controller (
  input  logic                          clk_i,
  input  logic                          rst_i,

  // Level-sensitive lines
  input  logic [irq_pkg::XLEN-1:0]      irq_i,

  // From CSR block
  input  logic [irq_pkg::XLEN-1:0]      mie_i,
  input  logic                          mstatus_mie_i,

  // To CSR block
  output logic [irq_pkg::XLEN-1:0]      mip_o,

  // To trap controller
  output logic                          irq_req_o,
  output logic [irq_pkg::IRQ_ID_W-1:0]  irq_id_o
);

  logic [irq_pkg::XLEN-1:0] mip_q;
  // Pending, enabled and globally allowed
  logic [irq_pkg::XLEN-1:0] irq_pend_en;

  // One flop of sampling, unimplemented lines dropped here
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_i & irq_pkg::IRQ_MASK;
    end
  end

  assign irq_pend_en = mip_q & mie_i & {irq_pkg::XLEN{mstatus_mie_i}};

  // Same cycle as mip
  assign irq_req_o = |irq_pend_en;

  //////////////////////////////////////////////////////////////////////
  // Priority encoder
  //////////////////////////////////////////////////////////////////////

  // Later assignments override earlier ones
  // Lowest first: 7, then 3, then 11, then 16 up to 31
  always_comb begin
    irq_id_o = '0;
    if (irq_pend_en[7]) begin
      irq_id_o = irq_pkg::IRQ_ID_W'(7);
    end
    if (irq_pend_en[3]) begin
      irq_id_o = irq_pkg::IRQ_ID_W'(3);
    end
    if (irq_pend_en[11]) begin
      irq_id_o = irq_pkg::IRQ_ID_W'(11);
    end
    // Platform lines, highest index wins
    for (int i = 16; i < irq_pkg::XLEN; i++) begin
      if (irq_pend_en[i]) begin
        irq_id_o = irq_pkg::IRQ_ID_W'(i);
      end
    end
  end

  assign mip_o = mip_q;

endmodule

/* irq_csr_regs.sv */
//////////////////////////////////////////////////////////////////////
// Machine CSRs for the interrupt path: mstatus, mie, mip, mtvec,
// mepc, mcause and mcycle. Written by strobe, read combinationally.
//////////////////////////////////////////////////////////////////////

module irq_csr_regs (
  input  logic                              clk_i,
  input  logic                              rst_i,

  // Software access
  input  logic                              csr_we_i,
  input  logic [irq_pkg::CSR_ADDR_W-1:0]    csr_addr_i,
  input  logic [irq_pkg::XLEN-1:0]          csr_wdata_i,
  input  logic [irq_pkg::CSR_ADDR_W-1:0]    csr_raddr_i,
  output logic [irq_pkg::XLEN-1:0]          csr_rdata_o,

  // From interrupt controller
  input  logic [irq_pkg::XLEN-1:0]          mip_i,

  // From trap controller
  input  logic                              trap_take_i,
  input  logic [irq_pkg::IRQ_ID_W-1:0]      trap_id_i,
  input  logic [irq_pkg::XLEN-1:0]          trap_pc_i,
  input  logic                              mret_take_i,

  // Interrupt steering
  output logic [irq_pkg::XLEN-1:0]          mie_o,
  output logic                              mstatus_mie_o,
  output logic [irq_pkg::XLEN-1:0]          mtvec_o,
  output logic [irq_pkg::XLEN-1:0]          mepc_o
);

  // Only MIE and MPIE exist in mstatus
  logic                              mstatus_mie_q;
  logic                              mstatus_mpie_q;
  logic [irq_pkg::XLEN-1:0]          mie_q;
  logic [irq_pkg::XLEN-1:0]          mtvec_q;
  logic [irq_pkg::XLEN-1:0]          mepc_q;
  logic                              mcause_irq_q;
  logic [irq_pkg::IRQ_ID_W-1:0]      mcause_id_q;
  logic [63:0]                       mcycle_q;

  // Per-register write decode
  logic mstatus_we;
  logic mie_we;
  logic mtvec_we;
  logic mepc_we;
  logic mcause_we;
  logic mcycle_we;
  logic mcycleh_we;

  logic [irq_pkg::XLEN-1:0] mstatus_rdata;
  logic [irq_pkg::XLEN-1:0] mcause_rdata;

  assign mstatus_we = csr_we_i && (csr_addr_i == irq_pkg::CSR_MSTATUS);
  assign mie_we     = csr_we_i && (csr_addr_i == irq_pkg::CSR_MIE);
  assign mtvec_we   = csr_we_i && (csr_addr_i == irq_pkg::CSR_MTVEC);
  assign mepc_we    = csr_we_i && (csr_addr_i == irq_pkg::CSR_MEPC);
  assign mcause_we  = csr_we_i && (csr_addr_i == irq_pkg::CSR_MCAUSE);
  assign mcycle_we  = csr_we_i && (csr_addr_i == irq_pkg::CSR_MCYCLE);
  assign mcycleh_we = csr_we_i && (csr_addr_i == irq_pkg::CSR_MCYCLEH);

  //////////////////////////////////////////////////////////////////////
  // Register updates
  //////////////////////////////////////////////////////////////////////

  // mstatus: mret first, then trap entry, then software
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mstatus_mie_q  <= irq_pkg::MSTATUS_RESET[irq_pkg::MSTATUS_MIE_BIT];
      mstatus_mpie_q <= irq_pkg::MSTATUS_RESET[irq_pkg::MSTATUS_MPIE_BIT];
    end else if (mret_take_i) begin
      // Restore enable, MPIE back to one
      mstatus_mie_q  <= mstatus_mpie_q;
      mstatus_mpie_q <= 1'b1;
    end else if (trap_take_i) begin
      // Stash enable and mask further interrupts
      mstatus_mpie_q <= mstatus_mie_q;
      mstatus_mie_q  <= 1'b0;
    end else if (mstatus_we) begin
      mstatus_mie_q  <= csr_wdata_i[irq_pkg::MSTATUS_MIE_BIT];
      mstatus_mpie_q <= csr_wdata_i[irq_pkg::MSTATUS_MPIE_BIT];
    end
  end

  // mie and mtvec are software only
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mie_q   <= '0;
      mtvec_q <= irq_pkg::MTVEC_RESET;
    end else begin
      if (mie_we) begin
        mie_q <= csr_wdata_i & irq_pkg::IRQ_MASK;
      end
      if (mtvec_we) begin
        // Bit 1 reserved, bit 0 selects vectored mode
        mtvec_q <= {csr_wdata_i[irq_pkg::XLEN-1:2], 1'b0, csr_wdata_i[0]};
      end
    end
  end

  // mepc and mcause, trap entry wins over software
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mepc_q       <= '0;
      mcause_irq_q <= 1'b0;
      mcause_id_q  <= '0;
    end else if (trap_take_i) begin
      mepc_q       <= {trap_pc_i[irq_pkg::XLEN-1:2], 2'b00};
      mcause_irq_q <= 1'b1;
      mcause_id_q  <= trap_id_i;
    end else begin
      if (mepc_we) begin
        mepc_q <= {csr_wdata_i[irq_pkg::XLEN-1:2], 2'b00};
      end
      if (mcause_we) begin
        mcause_irq_q <= csr_wdata_i[irq_pkg::XLEN-1];
        mcause_id_q  <= csr_wdata_i[irq_pkg::IRQ_ID_W-1:0];
      end
    end
  end

  // Free-running cycle counter; a written word holds for that edge
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mcycle_q <= '0;
    end else if (mcycle_we) begin
      mcycle_q <= {mcycle_q[63:32], csr_wdata_i};
    end else if (mcycleh_we) begin
      mcycle_q <= {csr_wdata_i, mcycle_q[31:0]};
    end else begin
      mcycle_q <= mcycle_q + 64'd1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    mstatus_rdata = '0;
    mstatus_rdata[irq_pkg::MSTATUS_MIE_BIT]  = mstatus_mie_q;
    mstatus_rdata[irq_pkg::MSTATUS_MPIE_BIT] = mstatus_mpie_q;
  end

  // Interrupt flag on top, cause id at the bottom
  assign mcause_rdata = {mcause_irq_q,
                         {(irq_pkg::XLEN-irq_pkg::IRQ_ID_W-1){1'b0}},
                         mcause_id_q};

  always_comb begin
    case (csr_raddr_i)
      irq_pkg::CSR_MSTATUS: csr_rdata_o = mstatus_rdata;
      irq_pkg::CSR_MIE:     csr_rdata_o = mie_q;
      irq_pkg::CSR_MTVEC:   csr_rdata_o = mtvec_q;
      irq_pkg::CSR_MEPC:    csr_rdata_o = mepc_q;
      irq_pkg::CSR_MCAUSE:  csr_rdata_o = mcause_rdata;
      irq_pkg::CSR_MIP:     csr_rdata_o = mip_i;
      irq_pkg::CSR_MCYCLE:  csr_rdata_o = mcycle_q[31:0];
      irq_pkg::CSR_MCYCLEH: csr_rdata_o = mcycle_q[63:32];
      // Unmapped reads as zero
      default:              csr_rdata_o = '0;
    endcase
  end

  assign mie_o         = mie_q;
  assign mstatus_mie_o = mstatus_mie_q;
  assign mtvec_o       = mtvec_q;
  assign mepc_o        = mepc_q;

endmodule

/* irq_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Shared constants for the machine-mode interrupt path
// Referenced by scoped names, e.g. irq_pkg::CSR_MIE
//////////////////////////////////////////////////////////////////////

package irq_pkg;

  // Widths
  localparam int unsigned XLEN       = 32;
  localparam int unsigned CSR_ADDR_W = 12;
  localparam int unsigned IRQ_ID_W   = 5;

  //////////////////////////////////////////////////////////////////////
  // CSR addresses
  //////////////////////////////////////////////////////////////////////

  localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS = 12'h300;
  localparam logic [CSR_ADDR_W-1:0] CSR_MIE     = 12'h304;
  localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC   = 12'h305;
  localparam logic [CSR_ADDR_W-1:0] CSR_MEPC    = 12'h341;
  localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE  = 12'h342;
  localparam logic [CSR_ADDR_W-1:0] CSR_MIP     = 12'h344;
  // Cycle counter, low and high words
  localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLE  = 12'hB00;
  localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLEH = 12'hB80;

  //////////////////////////////////////////////////////////////////////
  // Bit positions and masks
  //////////////////////////////////////////////////////////////////////

  // Global enable and its saved copy
  localparam int unsigned MSTATUS_MIE_BIT  = 3;
  localparam int unsigned MSTATUS_MPIE_BIT = 7;

  // Implemented lines: software 3, timer 7, external 11, platform 16..31
  localparam logic [XLEN-1:0] IRQ_MASK = 32'hFFFF0888;

  //////////////////////////////////////////////////////////////////////
  // Reset values
  //////////////////////////////////////////////////////////////////////

  // Direct mode, base at 0x1000
  localparam logic [XLEN-1:0] MTVEC_RESET   = 32'h0000_1000;
  localparam logic [XLEN-1:0] MSTATUS_RESET = 32'h0000_0000;

endpackage
